// File: design/epu_pkg.sv
`default_nettype none

package epu_pkg;

  // word and address widths.
  localparam int WORD_W      = 32;
  localparam int ADDR_W      = 9;
  localparam int DEPTH       = 512;
  localparam int BYTE_ADDR_W = 11;

  // element count runs 1..DEPTH, so one bit wider than the address.
  localparam int CNT_W  = 10;
  localparam int COEF_W = 16;  // signed weight and scale.

  // host buffer select.
  typedef enum logic {
    SEL_BIAS   = 1'b0,
    SEL_WEIGHT = 1'b1
  } buf_sel_e;

  // who read the sram in the previous cycle.
  typedef enum logic [1:0] {
    OWN_NONE   = 2'd0,
    OWN_HOST   = 2'd1,
    OWN_ENGINE = 2'd2
  } owner_e;

  // engine control states.
  typedef enum logic [1:0] {
    E_IDLE  = 2'd0,
    E_RUN   = 2'd1,
    E_DRAIN = 2'd2
  } eng_state_e;

endpackage

`default_nettype wire

// File: design/buf_sram.sv
`default_nettype none

module buf_sram (
  input  logic                       clk,
  input  logic                       cs_i,
  input  logic                       we_i,
  input  logic [epu_pkg::ADDR_W-1:0] addr_i,
  input  logic [epu_pkg::WORD_W-1:0] wdata_i,
  output logic [epu_pkg::WORD_W-1:0] rdata_o
);

  import epu_pkg::*;

  logic [WORD_W-1:0] mem [DEPTH];

  // single port, write wins the cycle.
  always_ff @(posedge clk) begin
    if (cs_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];  // one cycle read latency.
      end
    end
  end

endmodule

`default_nettype wire

// File: design/buf_wrapper.sv
`default_nettype none

module buf_wrapper #(
  parameter epu_pkg::buf_sel_e BUF_ID = epu_pkg::SEL_BIAS
) (
  input  logic                            clk,
  input  logic                            rst,
  // host strobe port.
  input  logic                            bus_rd_i,
  input  logic                            bus_wr_i,
  input  epu_pkg::buf_sel_e               bus_sel_i,
  input  logic [epu_pkg::BYTE_ADDR_W-1:0] bus_addr_i,
  input  logic [epu_pkg::WORD_W-1:0]      bus_wdata_i,
  // read return from the previous wrapper.
  input  logic                            chain_rvalid_i,
  input  logic [epu_pkg::WORD_W-1:0]      chain_rdata_i,
  output logic                            host_rvalid_o,
  output logic [epu_pkg::WORD_W-1:0]      host_rdata_o,
  // engine side.
  input  logic                            eng_req_i,
  input  logic [epu_pkg::ADDR_W-1:0]      eng_addr_i,
  output logic                            eng_gnt_o,
  output logic [epu_pkg::WORD_W-1:0]      eng_rdata_o
);

  import epu_pkg::*;

  logic              host_sel;
  logic              host_hit;
  logic              host_rd_hit;
  logic              sram_cs;
  logic              sram_we;
  logic [ADDR_W-1:0] sram_addr;
  logic [WORD_W-1:0] sram_rdata;
  owner_e            owner_q;
  logic              own_rvalid;
  logic [WORD_W-1:0] own_rdata;

  assign host_sel    = (bus_sel_i == BUF_ID);
  assign host_hit    = (bus_rd_i | bus_wr_i) & host_sel;
  assign host_rd_hit = bus_rd_i & host_sel;

  // host always wins, engine stalls.
  assign eng_gnt_o = eng_req_i & ~host_hit;

  assign sram_cs   = host_hit | eng_gnt_o;
  assign sram_we   = bus_wr_i & host_sel;
  assign sram_addr = host_hit ? bus_addr_i[10:2] : eng_addr_i;  // host addresses bytes.

  buf_sram u_sram (
    .clk    (clk),
    .cs_i   (sram_cs),
    .we_i   (sram_we),
    .addr_i (sram_addr),
    .wdata_i(bus_wdata_i),
    .rdata_o(sram_rdata)
  );

  // a host write returns nothing, so only reads claim the return path.
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      owner_q <= OWN_NONE;
    end else if (host_rd_hit) begin
      owner_q <= OWN_HOST;
    end else if (eng_gnt_o) begin
      owner_q <= OWN_ENGINE;
    end else begin
      owner_q <= OWN_NONE;
    end
  end

  always_comb begin
    own_rvalid  = 1'b0;
    own_rdata   = '0;
    eng_rdata_o = '0;
    case (owner_q)
      OWN_HOST: begin
        own_rvalid = 1'b1;
        own_rdata  = sram_rdata;
      end
      OWN_ENGINE: begin
        eng_rdata_o = sram_rdata;
      end
      default: begin
        own_rvalid = 1'b0;
      end
    endcase
  end

  // one strobe per cycle, so the two returns never overlap.
  assign host_rvalid_o = own_rvalid | chain_rvalid_i;
  assign host_rdata_o  = own_rdata | chain_rdata_i;

endmodule

`default_nettype wire

// File: design/epu_engine.sv
`default_nettype none

module epu_engine (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start_i,
  input  logic [epu_pkg::CNT_W-1:0]  count_i,
  input  logic [epu_pkg::COEF_W-1:0] scale_i,
  input  logic                       bias_gnt_i,
  input  logic                       weight_gnt_i,
  input  logic [epu_pkg::WORD_W-1:0] bias_rdata_i,
  input  logic [epu_pkg::WORD_W-1:0] weight_rdata_i,
  output logic                       eng_req_o,
  output logic [epu_pkg::ADDR_W-1:0] eng_addr_o,
  output logic                       res_valid_o,
  output logic [epu_pkg::ADDR_W-1:0] res_index_o,
  output logic [epu_pkg::WORD_W-1:0] res_data_o,
  output logic                       done_o,
  output logic                       busy_o
);

  import epu_pkg::*;

  eng_state_e               state_q;
  logic [CNT_W-1:0]         count_q;
  logic signed [COEF_W-1:0] scale_q;
  logic [ADDR_W-1:0]        addr_q;
  logic                     issue;
  logic                     last_issue;
  logic                     rd_valid_q;
  logic                     rd_last_q;
  logic [ADDR_W-1:0]        rd_idx_q;
  logic signed [WORD_W-1:0] prod;

  assign issue      = (state_q == E_RUN) & bias_gnt_i & weight_gnt_i;
  assign last_issue = issue & ({1'b0, addr_q} == count_q - CNT_W'(1));

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q <= E_IDLE;
      addr_q  <= '0;
    end else begin
      case (state_q)
        E_IDLE: begin
          if (start_i && count_i != '0) begin
            state_q <= E_RUN;
            addr_q  <= '0;
          end
        end
        E_RUN: begin
          if (last_issue) begin
            state_q <= E_DRAIN;
          end else if (issue) begin
            addr_q <= addr_q + ADDR_W'(1);
          end
        end
        E_DRAIN: begin
          if (done_o) begin
            state_q <= E_IDLE;  // busy drops a cycle after done.
          end
        end
        default: state_q <= E_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == E_IDLE && start_i) begin
      count_q <= count_i;
      scale_q <= scale_i;
    end
  end

  // read stage, data lands a cycle after the issue.
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rd_valid_q <= 1'b0;
      rd_last_q  <= 1'b0;
    end else begin
      rd_valid_q <= issue;
      rd_last_q  <= last_issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      rd_idx_q <= addr_q;
    end
  end

  // weight is the signed low half of the word.
  assign prod = $signed(weight_rdata_i[COEF_W-1:0]) * scale_q;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      res_valid_o <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      res_valid_o <= rd_valid_q;
      done_o      <= rd_valid_q & rd_last_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid_q) begin
      res_index_o <= rd_idx_q;
      res_data_o  <= prod + bias_rdata_i;  // wraps at 32 bits.
    end
  end

  assign eng_req_o  = (state_q == E_RUN);
  assign eng_addr_o = addr_q;
  assign busy_o     = (state_q != E_IDLE);

endmodule

`default_nettype wire

// File: design/epu_top.sv
`default_nettype none

module epu_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            bus_rd_i,
  input  logic                            bus_wr_i,
  input  epu_pkg::buf_sel_e               bus_sel_i,
  input  logic [epu_pkg::BYTE_ADDR_W-1:0] bus_addr_i,
  input  logic [epu_pkg::WORD_W-1:0]      bus_wdata_i,
  output logic                            bus_rvalid_o,
  output logic [epu_pkg::WORD_W-1:0]      bus_rdata_o,
  input  logic                            start_i,
  input  logic [epu_pkg::CNT_W-1:0]       count_i,
  input  logic [epu_pkg::COEF_W-1:0]      scale_i,
  output logic                            res_valid_o,
  output logic [epu_pkg::ADDR_W-1:0]      res_index_o,
  output logic [epu_pkg::WORD_W-1:0]      res_data_o,
  output logic                            done_o,
  output logic                            busy_o
);

  import epu_pkg::*;

  logic              eng_req;
  logic [ADDR_W-1:0] eng_addr;
  logic              bias_gnt;
  logic              weight_gnt;
  logic [WORD_W-1:0] bias_rdata;
  logic [WORD_W-1:0] weight_rdata;
  logic              bias_rvalid;
  logic [WORD_W-1:0] bias_host_rdata;

  // first in the read chain.
  buf_wrapper #(.BUF_ID(SEL_BIAS)) u_bias_buf (
    .clk           (clk),
    .rst           (rst),
    .bus_rd_i      (bus_rd_i),
    .bus_wr_i      (bus_wr_i),
    .bus_sel_i     (bus_sel_i),
    .bus_addr_i    (bus_addr_i),
    .bus_wdata_i   (bus_wdata_i),
    .chain_rvalid_i(1'b0),
    .chain_rdata_i ({WORD_W{1'b0}}),
    .host_rvalid_o (bias_rvalid),
    .host_rdata_o  (bias_host_rdata),
    .eng_req_i     (eng_req),
    .eng_addr_i    (eng_addr),
    .eng_gnt_o     (bias_gnt),
    .eng_rdata_o   (bias_rdata)
  );

  buf_wrapper #(.BUF_ID(SEL_WEIGHT)) u_weight_buf (
    .clk           (clk),
    .rst           (rst),
    .bus_rd_i      (bus_rd_i),
    .bus_wr_i      (bus_wr_i),
    .bus_sel_i     (bus_sel_i),
    .bus_addr_i    (bus_addr_i),
    .bus_wdata_i   (bus_wdata_i),
    .chain_rvalid_i(bias_rvalid),
    .chain_rdata_i (bias_host_rdata),
    .host_rvalid_o (bus_rvalid_o),
    .host_rdata_o  (bus_rdata_o),
    .eng_req_i     (eng_req),
    .eng_addr_i    (eng_addr),
    .eng_gnt_o     (weight_gnt),
    .eng_rdata_o   (weight_rdata)
  );

  epu_engine u_engine (
    .clk           (clk),
    .rst           (rst),
    .start_i       (start_i),
    .count_i       (count_i),
    .scale_i       (scale_i),
    .bias_gnt_i    (bias_gnt),
    .weight_gnt_i  (weight_gnt),
    .bias_rdata_i  (bias_rdata),
    .weight_rdata_i(weight_rdata),
    .eng_req_o     (eng_req),
    .eng_addr_o    (eng_addr),
    .res_valid_o   (res_valid_o),
    .res_index_o   (res_index_o),
    .res_data_o    (res_data_o),
    .done_o        (done_o),
    .busy_o        (busy_o)
  );

endmodule

`default_nettype wire

// File: bench/epu_props.sv
`default_nettype none

module epu_props (
  input logic clk,
  input logic rst,
  input logic bus_rd_i,
  input logic bus_rvalid_o,
  input logic res_valid_o,
  input logic done_o,
  input logic busy_o
);

  timeunit 1ns;
  timeprecision 100ps;

  rvalid_after_read: assert property (@(posedge clk) disable iff (rst)
    bus_rvalid_o |-> $past(bus_rd_i))
    else $error("bus_rvalid_o high without a read strobe one cycle earlier");

  // results only inside a run.
  stream_while_busy: assert property (@(posedge clk) disable iff (rst)
    (res_valid_o || done_o) |-> busy_o)
    else $error("result or done seen while the engine is idle");

  done_with_result: assert property (@(posedge clk) disable iff (rst)
    done_o |-> res_valid_o)
    else $error("done_o high without res_valid_o");

endmodule

bind epu_top epu_props u_props (
  .clk         (clk),
  .rst         (rst),
  .bus_rd_i    (bus_rd_i),
  .bus_rvalid_o(bus_rvalid_o),
  .res_valid_o (res_valid_o),
  .done_o      (done_o),
  .busy_o      (busy_o)
);

`default_nettype wire

// File: bench/epu_tb.sv
`default_nettype none

module epu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import epu_pkg::*;

  logic                   clk;
  logic                   rst;
  logic                   bus_rd;
  logic                   bus_wr;
  buf_sel_e               bus_sel;
  logic [BYTE_ADDR_W-1:0] bus_addr;
  logic [WORD_W-1:0]      bus_wdata;
  logic                   bus_rvalid;
  logic [WORD_W-1:0]      bus_rdata;
  logic                   start;
  logic [CNT_W-1:0]       count;
  logic [COEF_W-1:0]      scale;
  logic                   res_valid;
  logic [ADDR_W-1:0]      res_index;
  logic [WORD_W-1:0]      res_data;
  logic                   done;
  logic                   busy;

  logic [WORD_W-1:0] bias_model [DEPTH];
  logic [WORD_W-1:0] weight_model [DEPTH];
  int unsigned       exp_index [$];
  logic [WORD_W-1:0] exp_data [$];
  int unsigned       check_count = 0;
  int unsigned       error_count = 0;
  int unsigned       timeout_count = 0;
  int unsigned       result_count = 0;

  epu_top u_epu_top (
    .clk         (clk),
    .rst         (rst),
    .bus_rd_i    (bus_rd),
    .bus_wr_i    (bus_wr),
    .bus_sel_i   (bus_sel),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .bus_rvalid_o(bus_rvalid),
    .bus_rdata_o (bus_rdata),
    .start_i     (start),
    .count_i     (count),
    .scale_i     (scale),
    .res_valid_o (res_valid),
    .res_index_o (res_index),
    .res_data_o  (res_data),
    .done_o      (done),
    .busy_o      (busy)
  );

  always #4 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    check_count++;
    if (act_val !== exp_val) begin
      error_count++;
      $display("** Error %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  // sign extend both factors, then keep the low 32 bits.
  function automatic logic [WORD_W-1:0] expected_result(input logic [WORD_W-1:0] weight,
                                                        input logic [WORD_W-1:0] bias,
                                                        input logic [COEF_W-1:0] scl);
    logic [WORD_W-1:0] w_ext;
    logic [WORD_W-1:0] s_ext;
    w_ext = {{16{weight[15]}}, weight[15:0]};
    s_ext = {{16{scl[15]}}, scl};
    return w_ext * s_ext + bias;
  endfunction

  function automatic buf_sel_e random_sel();
    return ($urandom_range(1, 0) == 1) ? SEL_WEIGHT : SEL_BIAS;
  endfunction

  // all tasks start and end on a falling edge.
  task automatic host_write(input buf_sel_e sel, input logic [ADDR_W-1:0] addr,
                            input logic [WORD_W-1:0] data);
    bus_wr    = 1'b1;
    bus_sel   = sel;
    bus_addr  = {addr, 2'($urandom)};  // byte offset is ignored.
    bus_wdata = data;
    if (sel == SEL_BIAS) begin
      bias_model[addr] = data;
    end else begin
      weight_model[addr] = data;
    end
    @(negedge clk);
    bus_wr = 1'b0;
  endtask

  task automatic host_read(input buf_sel_e sel, input logic [ADDR_W-1:0] addr);
    logic [WORD_W-1:0] exp_word;
    string             name;
    exp_word = (sel == SEL_BIAS) ? bias_model[addr] : weight_model[addr];
    name     = (sel == SEL_BIAS) ? "bias read data" : "weight read data";
    bus_rd   = 1'b1;
    bus_sel  = sel;
    bus_addr = {addr, 2'($urandom)};
    @(negedge clk);
    bus_rd = 1'b0;
    check_value("read valid", 32'd1, 32'(bus_rvalid));
    check_value(name, exp_word, bus_rdata);
  endtask

  task automatic start_run(input logic [CNT_W-1:0] cnt, input logic [COEF_W-1:0] scl);
    for (int i = 0; i < int'(cnt); i++) begin
      exp_index.push_back(i);
      exp_data.push_back(expected_result(weight_model[i], bias_model[i], scl));
    end
    start = 1'b1;
    count = cnt;
    scale = scl;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_first_result(input int limit, output int cycles);
    cycles = 0;
    while (!res_valid && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!res_valid) begin
      timeout_count++;
      $display("timeout: no result within %0d cycles of the start", limit);
    end
  endtask

  task automatic wait_run_done(input int limit, input bit host_reads);
    int cycles;
    cycles = 0;
    while (!done && cycles < limit) begin
      if (host_reads && $urandom_range(2, 0) == 0) begin
        host_read(random_sel(), ADDR_W'($urandom_range(DEPTH - 1, 0)));
      end else begin
        @(negedge clk);
      end
      cycles++;
    end
    if (!done) begin
      timeout_count++;
      $display("timeout: run did not signal done within %0d cycles", limit);
    end
    @(negedge clk);
    check_value("busy after done", 32'd0, 32'(busy));
    check_value("results pending", 32'd0, exp_data.size());
  endtask

  task automatic fill_buffers();
    for (int a = 0; a < DEPTH; a++) begin
      host_write(SEL_BIAS, ADDR_W'(a), $urandom);
      host_write(SEL_WEIGHT, ADDR_W'(a), $urandom);
    end
    repeat (32) begin
      host_write(random_sel(), ADDR_W'($urandom_range(DEPTH - 1, 0)), $urandom);
    end
  endtask

  // same address in both buffers, so aliasing shows up.
  task automatic read_back_random(input int reads);
    logic [ADDR_W-1:0] addr;
    repeat (reads) begin
      addr = ADDR_W'($urandom_range(DEPTH - 1, 0));
      host_read(SEL_BIAS, addr);
      host_read(SEL_WEIGHT, addr);
    end
  endtask

  task automatic run_quiet();
    logic [CNT_W-1:0] cnt;
    int               lat;
    cnt = CNT_W'($urandom_range(DEPTH, 1));
    start_run(cnt, COEF_W'($urandom));
    wait_first_result(10, lat);
    check_value("first result latency", 32'd3, 32'(lat + 1));
    for (int i = 0; i < int'(cnt) - 1; i++) begin
      @(negedge clk);
      check_value("back to back results", 32'd1, 32'(res_valid));
    end
    check_value("done with last result", 32'd1, 32'(done));
    @(negedge clk);
    check_value("busy after done", 32'd0, 32'(busy));
    check_value("results pending", 32'd0, exp_data.size());
  endtask

  task automatic ignored_starts();
    logic [CNT_W-1:0] cnt;
    int unsigned      seen;
    cnt = CNT_W'($urandom_range(60, 20));
    start_run(cnt, COEF_W'($urandom));
    repeat (5) @(negedge clk);
    start = 1'b1;  // dropped while busy.
    count = CNT_W'(7);
    @(negedge clk);
    start = 1'b0;
    wait_run_done(int'(cnt) + 40, 1'b0);
    seen  = result_count;
    start = 1'b1;
    count = '0;
    @(negedge clk);
    start = 1'b0;
    repeat (8) @(negedge clk);
    check_value("busy after zero count", 32'd0, 32'(busy));
    check_value("results after zero count", seen, result_count);
  endtask

  // result stream against the expected queue.
  always @(negedge clk) begin
    if (!rst && res_valid) begin
      result_count++;
      if (exp_data.size() == 0) begin
        error_count++;
        $display("result at index %0d arrived with no result pending", res_index);
      end else begin
        check_value("result index", exp_index.pop_front(), 32'(res_index));
        check_value("result data", exp_data.pop_front(), res_data);
        check_value("done flag", 32'(exp_data.size() == 0), 32'(done));
      end
    end
  end

  initial begin
    int unsigned      seed_ret;
    logic [CNT_W-1:0] cnt;
    seed_ret  = $urandom(32'h3fecca57);
    clk       = 1'b0;
    rst       = 1'b1;
    bus_rd    = 1'b0;
    bus_wr    = 1'b0;
    bus_sel   = SEL_BIAS;
    bus_addr  = '0;
    bus_wdata = '0;
    start     = 1'b0;
    count     = '0;
    scale     = '0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("reset bus_rvalid", 32'd0, 32'(bus_rvalid));
    check_value("reset res_valid", 32'd0, 32'(res_valid));
    check_value("reset done", 32'd0, 32'(done));
    check_value("reset busy", 32'd0, 32'(busy));
    fill_buffers();
    read_back_random(64);
    repeat (3) run_quiet();
    repeat (3) begin
      cnt = CNT_W'($urandom_range(200, 40));
      start_run(cnt, COEF_W'($urandom));
      wait_run_done(3 * int'(cnt) + 50, 1'b1);
    end
    ignored_starts();
    $display("checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
design/epu_pkg.sv
design/buf_sram.sv
design/buf_wrapper.sv
design/epu_engine.sv
design/epu_top.sv
bench/epu_props.sv
bench/epu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= epu_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
